// File: source/ex_isa_pkg.sv
package ex_isa_pkg;

    typedef logic [31:0] word_t;       // Data, address and instruction word
    typedef logic [4:0]  reg_idx_t;    // Register file index
    typedef logic [4:0]  shamt_t;      // Shift amount
    typedef logic [6:0]  opcode_t;     // Major opcode field
    typedef logic [2:0]  funct3_t;     // Minor opcode field
    typedef logic [6:0]  funct7_t;     // Upper function field

    // Major opcodes handled in execute
    localparam opcode_t OPC_OP     = 7'b0110011;    // Register-register ALU
    localparam opcode_t OPC_OP_IMM = 7'b0010011;    // Register-immediate ALU
    localparam opcode_t OPC_LUI    = 7'b0110111;    // Load upper immediate
    localparam opcode_t OPC_AUIPC  = 7'b0010111;    // Add upper immediate to PC
    localparam opcode_t OPC_BRANCH = 7'b1100011;    // Conditional branches
    localparam opcode_t OPC_JAL    = 7'b1101111;    // Jump and link
    localparam opcode_t OPC_JALR   = 7'b1100111;    // Jump and link register

    // funct3 for ALU operations
    localparam funct3_t F3_ADD  = 3'b000;    // ADD, SUB, ADDI
    localparam funct3_t F3_SLL  = 3'b001;    // Shift left
    localparam funct3_t F3_SLT  = 3'b010;    // Signed compare
    localparam funct3_t F3_SLTU = 3'b011;    // Unsigned compare
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101;    // SRL or SRA by funct7
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    // funct3 for conditional branches
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;
    localparam funct3_t F3_JALR = 3'b000;    // Only legal JALR funct3

    // funct7 variants
    localparam funct7_t FUNCT7_BASE = 7'b0000000;    // Normal operation
    localparam funct7_t FUNCT7_ALT  = 7'b0100000;    // SUB and SRA select

    localparam word_t INSTR_BYTES = 32'd4;    // PC step per instruction

endpackage

// File: source/ex_ctrl_pkg.sv
package ex_ctrl_pkg;

    // ALU operation, one per RV32I integer function
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,     // Signed less-than
        ALU_SLTU,    // Unsigned less-than
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,     // Sign bit shifted in
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // First ALU operand source
    typedef enum logic [1:0] {
        OPA_RS1,     // Register rs1
        OPA_PC,      // AUIPC
        OPA_ZERO     // LUI
    } opa_sel_e;

    // Second ALU operand source
    typedef enum logic {
        OPB_RS2,
        OPB_IMM
    } opb_sel_e;

    // Branch unit condition
    typedef enum logic [3:0] {
        BR_NONE,     // No control transfer
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU,
        BR_JAL,      // Unconditional, PC relative
        BR_JALR      // Unconditional, register relative
    } br_cond_e;

    // Source of the written-back result
    typedef enum logic {
        RES_ALU,
        RES_LINK     // Return address of JAL and JALR
    } res_sel_e;

endpackage

// File: source/ex_imm_gen.sv
module ex_imm_gen (
    input  ex_isa_pkg::word_t instr,    // Instruction word
    output ex_isa_pkg::word_t imm_i,    // OP-IMM and JALR
    output ex_isa_pkg::word_t imm_b,    // Branch offset
    output ex_isa_pkg::word_t imm_u,    // LUI and AUIPC
    output ex_isa_pkg::word_t imm_j     // JAL offset
);

    logic sign;    // Every format keeps its sign in bit 31

    assign sign = instr[31];

    // I format: imm[11:0] = instr[31:20]
    assign imm_i = {{20{sign}}, instr[31:20]};

    // B format, offset in halfwords so bit 0 is zero
    assign imm_b = {{19{sign}},
                    sign,               // imm[12]
                    instr[7],           // imm[11]
                    instr[30:25],       // imm[10:5]
                    instr[11:8],        // imm[4:1]
                    1'b0};              // Implicit zero

    // U format, low twelve bits cleared
    assign imm_u = {instr[31:12], 12'b0};

    // J format, bits scattered across the upper word
    assign imm_j = {{11{sign}},
                    sign,               // imm[20]
                    instr[19:12],       // imm[19:12]
                    instr[20],          // imm[11]
                    instr[30:21],       // imm[10:1]
                    1'b0};              // Implicit zero

endmodule

// File: source/ex_decode.sv
module ex_decode (
    input  ex_isa_pkg::word_t      instr,       // Instruction word
    output ex_ctrl_pkg::alu_op_e   alu_op,      // ALU function
    output ex_ctrl_pkg::opa_sel_e  opa_sel,     // Operand a source
    output ex_ctrl_pkg::opb_sel_e  opb_sel,     // Operand b source
    output logic                   imm_sel,     // High picks the U immediate
    output ex_ctrl_pkg::br_cond_e  br_cond,     // Branch unit condition
    output ex_ctrl_pkg::res_sel_e  res_sel,     // Result source
    output logic                   rd_write,    // Register write enable
    output logic                   illegal      // Unsupported encoding
);

    ex_isa_pkg::opcode_t   opcode;
    ex_isa_pkg::funct3_t   funct3;
    ex_isa_pkg::funct7_t   funct7;
    ex_isa_pkg::reg_idx_t  rd;
    ex_ctrl_pkg::br_cond_e br_raw;     // Condition before legality gating
    logic                  base;       // funct7 all zero
    logic                  alt;        // funct7 selects SUB or SRA
    logic                  writes;     // Format writes rd
    logic                  legal;

    // Shared funct3 to ALU mapping for OP and OP-IMM
    function automatic ex_ctrl_pkg::alu_op_e alu_from_f3(ex_isa_pkg::funct3_t f3, logic sel_alt);
        case (f3)
            ex_isa_pkg::F3_ADD:  return sel_alt ? ex_ctrl_pkg::ALU_SUB : ex_ctrl_pkg::ALU_ADD;
            ex_isa_pkg::F3_SLL:  return ex_ctrl_pkg::ALU_SLL;
            ex_isa_pkg::F3_SLT:  return ex_ctrl_pkg::ALU_SLT;
            ex_isa_pkg::F3_SLTU: return ex_ctrl_pkg::ALU_SLTU;
            ex_isa_pkg::F3_XOR:  return ex_ctrl_pkg::ALU_XOR;
            ex_isa_pkg::F3_SR:   return sel_alt ? ex_ctrl_pkg::ALU_SRA : ex_ctrl_pkg::ALU_SRL;
            ex_isa_pkg::F3_OR:   return ex_ctrl_pkg::ALU_OR;
            default:             return ex_ctrl_pkg::ALU_AND;    // F3_AND
        endcase
    endfunction

    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign base   = (funct7 == ex_isa_pkg::FUNCT7_BASE);
    assign alt    = (funct7 == ex_isa_pkg::FUNCT7_ALT);

    always_comb begin
        alu_op  = ex_ctrl_pkg::ALU_ADD;    // Defaults suit an address add
        opa_sel = ex_ctrl_pkg::OPA_RS1;
        opb_sel = ex_ctrl_pkg::OPB_RS2;
        imm_sel = 1'b0;
        br_raw  = ex_ctrl_pkg::BR_NONE;
        res_sel = ex_ctrl_pkg::RES_ALU;
        writes  = 1'b0;
        legal   = 1'b1;
        case (opcode)
            ex_isa_pkg::OPC_OP: begin
                writes = 1'b1;
                alu_op = alu_from_f3(funct3, alt);
                // Alternate funct7 only exists for SUB and SRA
                legal  = base || (alt && (funct3 == ex_isa_pkg::F3_ADD ||
                                          funct3 == ex_isa_pkg::F3_SR));
            end
            ex_isa_pkg::OPC_OP_IMM: begin
                writes  = 1'b1;
                opb_sel = ex_ctrl_pkg::OPB_IMM;
                alu_op  = alu_from_f3(funct3, alt && funct3 == ex_isa_pkg::F3_SR);    // No SUBI
                if (funct3 == ex_isa_pkg::F3_SLL) begin
                    legal = base;                                                 // SLLI
                end else if (funct3 == ex_isa_pkg::F3_SR) begin
                    legal = base || alt;                                          // SRLI or SRAI
                end
            end
            ex_isa_pkg::OPC_LUI: begin
                writes  = 1'b1;
                opa_sel = ex_ctrl_pkg::OPA_ZERO;    // 0 + imm_u
                opb_sel = ex_ctrl_pkg::OPB_IMM;
                imm_sel = 1'b1;
            end
            ex_isa_pkg::OPC_AUIPC: begin
                writes  = 1'b1;
                opa_sel = ex_ctrl_pkg::OPA_PC;      // pc + imm_u
                opb_sel = ex_ctrl_pkg::OPB_IMM;
                imm_sel = 1'b1;
            end
            ex_isa_pkg::OPC_BRANCH: begin
                case (funct3)
                    ex_isa_pkg::F3_BEQ:  br_raw = ex_ctrl_pkg::BR_EQ;
                    ex_isa_pkg::F3_BNE:  br_raw = ex_ctrl_pkg::BR_NE;
                    ex_isa_pkg::F3_BLT:  br_raw = ex_ctrl_pkg::BR_LT;
                    ex_isa_pkg::F3_BGE:  br_raw = ex_ctrl_pkg::BR_GE;
                    ex_isa_pkg::F3_BLTU: br_raw = ex_ctrl_pkg::BR_LTU;
                    ex_isa_pkg::F3_BGEU: br_raw = ex_ctrl_pkg::BR_GEU;
                    default:             legal  = 1'b0;    // 010 and 011 reserved
                endcase
            end
            ex_isa_pkg::OPC_JAL: begin
                writes  = 1'b1;
                br_raw  = ex_ctrl_pkg::BR_JAL;
                res_sel = ex_ctrl_pkg::RES_LINK;
            end
            ex_isa_pkg::OPC_JALR: begin
                writes  = 1'b1;
                br_raw  = ex_ctrl_pkg::BR_JALR;
                res_sel = ex_ctrl_pkg::RES_LINK;
                legal   = (funct3 == ex_isa_pkg::F3_JALR);
            end
            default: legal = 1'b0;    // Loads, stores, system and the rest
        endcase
    end

    assign illegal  = !legal;
    assign rd_write = legal && writes && (rd != '0);    // x0 is never written
    assign br_cond  = legal ? br_raw : ex_ctrl_pkg::BR_NONE;

endmodule

// File: source/ex_alu.sv
module ex_alu (
    input  ex_isa_pkg::word_t      pc,          // Instruction address
    input  ex_isa_pkg::word_t      rs1_data,
    input  ex_isa_pkg::word_t      rs2_data,
    input  ex_isa_pkg::word_t      imm,         // I immediate
    input  ex_isa_pkg::word_t      imm_u,       // U immediate
    input  logic                   imm_sel,     // High picks imm_u
    input  ex_ctrl_pkg::alu_op_e   alu_op,
    input  ex_ctrl_pkg::opa_sel_e  opa_sel,
    input  ex_ctrl_pkg::opb_sel_e  opb_sel,
    output ex_isa_pkg::word_t      alu_result
);

    ex_isa_pkg::word_t  opa;
    ex_isa_pkg::word_t  opb;
    ex_isa_pkg::word_t  imm_val;    // Immediate after format select
    ex_isa_pkg::shamt_t shamt;

    always_comb begin
        case (opa_sel)
            ex_ctrl_pkg::OPA_PC:   opa = pc;      // AUIPC
            ex_ctrl_pkg::OPA_ZERO: opa = '0;      // LUI
            default:               opa = rs1_data;
        endcase
    end

    assign imm_val = imm_sel ? imm_u : imm;
    assign opb     = (opb_sel == ex_ctrl_pkg::OPB_IMM) ? imm_val : rs2_data;
    assign shamt   = opb[4:0];    // Upper bits ignored for shifts

    always_comb begin
        case (alu_op)
            ex_ctrl_pkg::ALU_ADD:  alu_result = opa + opb;
            ex_ctrl_pkg::ALU_SUB:  alu_result = opa - opb;
            ex_ctrl_pkg::ALU_SLL:  alu_result = opa << shamt;
            ex_ctrl_pkg::ALU_SLT:  alu_result = {31'b0, $signed(opa) < $signed(opb)};
            ex_ctrl_pkg::ALU_SLTU: alu_result = {31'b0, opa < opb};
            ex_ctrl_pkg::ALU_XOR:  alu_result = opa ^ opb;
            ex_ctrl_pkg::ALU_SRL:  alu_result = opa >> shamt;
            ex_ctrl_pkg::ALU_SRA:  alu_result = ex_isa_pkg::word_t'($signed(opa) >>> shamt);
            ex_ctrl_pkg::ALU_OR:   alu_result = opa | opb;
            ex_ctrl_pkg::ALU_AND:  alu_result = opa & opb;
            default:               alu_result = '0;    // Unused enum codes
        endcase
    end

endmodule

// File: source/ex_branch_unit.sv
module ex_branch_unit (
    input  ex_isa_pkg::word_t     pc,
    input  ex_isa_pkg::word_t     rs1_data,
    input  ex_isa_pkg::word_t     rs2_data,
    input  ex_isa_pkg::word_t     imm_i,       // JALR offset
    input  ex_isa_pkg::word_t     imm_b,       // Branch offset
    input  ex_isa_pkg::word_t     imm_j,       // JAL offset
    input  ex_ctrl_pkg::br_cond_e br_cond,
    output logic                  redirect,    // Fetch must restart at target
    output ex_isa_pkg::word_t     target,
    output ex_isa_pkg::word_t     link         // Return address
);

    logic              eq;
    logic              lt;          // Signed rs1 < rs2
    logic              ltu;         // Unsigned rs1 < rs2
    ex_isa_pkg::word_t jalr_sum;    // Register relative target before alignment

    assign eq  = (rs1_data == rs2_data);
    assign lt  = ($signed(rs1_data) < $signed(rs2_data));
    assign ltu = (rs1_data < rs2_data);

    always_comb begin
        case (br_cond)
            ex_ctrl_pkg::BR_EQ:   redirect = eq;
            ex_ctrl_pkg::BR_NE:   redirect = !eq;
            ex_ctrl_pkg::BR_LT:   redirect = lt;
            ex_ctrl_pkg::BR_GE:   redirect = !lt;
            ex_ctrl_pkg::BR_LTU:  redirect = ltu;
            ex_ctrl_pkg::BR_GEU:  redirect = !ltu;
            ex_ctrl_pkg::BR_JAL,
            ex_ctrl_pkg::BR_JALR: redirect = 1'b1;    // Jumps always redirect
            default:              redirect = 1'b0;    // BR_NONE
        endcase
    end

    assign jalr_sum = rs1_data + imm_i;

    always_comb begin
        case (br_cond)
            ex_ctrl_pkg::BR_JAL:  target = pc + imm_j;
            ex_ctrl_pkg::BR_JALR: target = {jalr_sum[31:1], 1'b0};    // Bit 0 cleared
            default:              target = pc + imm_b;
        endcase
    end

    assign link = pc + ex_isa_pkg::INSTR_BYTES;

endmodule

// File: source/ex_output_stage.sv
module ex_output_stage (
    input  logic                  clk,
    input  logic                  reset,         // Synchronous, active high
    input  logic                  in_valid,      // Instruction present this cycle
    input  ex_isa_pkg::word_t     instr,
    input  ex_ctrl_pkg::res_sel_e res_sel,
    input  ex_isa_pkg::word_t     alu_result,
    input  ex_isa_pkg::word_t     link,
    input  ex_isa_pkg::word_t     target,
    input  logic                  redirect,
    input  logic                  rd_write,
    input  logic                  illegal,
    output logic                  out_valid,
    output ex_isa_pkg::word_t     result,
    output ex_isa_pkg::reg_idx_t  rd,
    output logic                  rd_write_q,
    output logic                  redirect_q,
    output logic                  illegal_q,
    output ex_isa_pkg::word_t     target_q
);

    ex_isa_pkg::word_t result_d;    // Selected write-back value

    assign result_d = (res_sel == ex_ctrl_pkg::RES_LINK) ? link : alu_result;

    // Flags, cleared on reset and dropped on idle cycles
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid  <= 1'b0;
            rd_write_q <= 1'b0;
            redirect_q <= 1'b0;
            illegal_q  <= 1'b0;
        end else begin
            out_valid  <= in_valid;
            rd_write_q <= in_valid && rd_write;
            redirect_q <= in_valid && redirect;
            illegal_q  <= in_valid && illegal;
        end
    end

    // Payload, only meaningful with out_valid
    always_ff @(posedge clk) begin
        result   <= result_d;
        rd       <= instr[11:7];
        target_q <= target;
    end

    // Decode must never request a write to x0
    a_no_x0_write: assert property (@(posedge clk) disable iff (reset)
        rd_write_q |-> (rd != '0));

    // Illegal encodings leave no side effect from decode or branch unit
    a_illegal_quiet: assert property (@(posedge clk) disable iff (reset)
        in_valid && illegal |=> !rd_write_q && !redirect_q);

endmodule

// File: source/ex_top.sv
module ex_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,    // From decode stage
    input  ex_isa_pkg::word_t    pc,
    input  ex_isa_pkg::word_t    instr,
    input  ex_isa_pkg::word_t    rs1_data,
    input  ex_isa_pkg::word_t    rs2_data,
    output logic                 out_valid,   // To memory stage
    output ex_isa_pkg::word_t    result,
    output ex_isa_pkg::reg_idx_t rd,
    output logic                 rd_write,
    output logic                 redirect,
    output logic                 illegal,
    output ex_isa_pkg::word_t    target
);

    ex_isa_pkg::word_t     imm_i, imm_b, imm_u, imm_j;    // Decoded immediates
    ex_ctrl_pkg::alu_op_e  alu_op;
    ex_ctrl_pkg::opa_sel_e opa_sel;
    ex_ctrl_pkg::opb_sel_e opb_sel;
    ex_ctrl_pkg::br_cond_e br_cond;
    ex_ctrl_pkg::res_sel_e res_sel;
    logic                  imm_sel;
    logic                  dec_rd_write;    // Combinational, before registering
    logic                  dec_illegal;
    logic                  br_redirect;
    ex_isa_pkg::word_t     br_target, link, alu_result;

    ex_imm_gen i_imm_gen (.instr, .imm_i, .imm_b, .imm_u, .imm_j);

    ex_decode i_decode (.instr, .alu_op, .opa_sel, .opb_sel, .imm_sel, .br_cond, .res_sel,
        .rd_write(dec_rd_write), .illegal(dec_illegal));

    ex_alu i_alu (.pc, .rs1_data, .rs2_data, .imm(imm_i), .imm_u, .imm_sel,
        .alu_op, .opa_sel, .opb_sel, .alu_result);

    ex_branch_unit i_branch_unit (.pc, .rs1_data, .rs2_data, .imm_i, .imm_b, .imm_j,
        .br_cond, .redirect(br_redirect), .target(br_target), .link);

    ex_output_stage i_output_stage (
        .clk,
        .reset,
        .in_valid,
        .instr,
        .res_sel,
        .alu_result,
        .link,
        .target     (br_target),
        .redirect   (br_redirect),
        .rd_write   (dec_rd_write),
        .illegal    (dec_illegal),
        .out_valid,
        .result,
        .rd,
        .rd_write_q (rd_write),
        .redirect_q (redirect),
        .illegal_q  (illegal),
        .target_q   (target)
    );

endmodule

// File: verif/tb_ex_tasks.svh
// Encoders with rs1 = x1 and rs2 = x2
function automatic ex_isa_pkg::word_t enc_r(ex_isa_pkg::funct7_t f7, ex_isa_pkg::funct3_t f3,
                                            ex_isa_pkg::reg_idx_t rd_i);
    return {f7, 5'd2, 5'd1, f3, rd_i, ex_isa_pkg::OPC_OP};
endfunction

function automatic ex_isa_pkg::word_t enc_i(logic [11:0] imm, ex_isa_pkg::funct3_t f3,
                                            ex_isa_pkg::reg_idx_t rd_i, ex_isa_pkg::opcode_t op);
    return {imm, 5'd1, f3, rd_i, op};
endfunction

function automatic ex_isa_pkg::word_t enc_b(logic [12:0] off, ex_isa_pkg::funct3_t f3);
    return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], ex_isa_pkg::OPC_BRANCH};
endfunction

function automatic ex_isa_pkg::word_t enc_j(logic [20:0] off, ex_isa_pkg::reg_idx_t rd_i);
    return {off[20], off[10:1], off[11], off[19:12], rd_i, ex_isa_pkg::OPC_JAL};
endfunction

// Signs differ so the negative one is smaller
function automatic logic less_signed(ex_isa_pkg::word_t a, ex_isa_pkg::word_t b);
    return (a[31] != b[31]) ? a[31] : (a < b);
endfunction

function automatic ex_isa_pkg::word_t alu_ref(ex_isa_pkg::funct3_t f3, logic alt,
                                              ex_isa_pkg::word_t a, ex_isa_pkg::word_t b);
    ex_isa_pkg::shamt_t sh;
    sh = b[4:0];    // Low five bits only
    case (f3)
        ex_isa_pkg::F3_ADD:  return alt ? a - b : a + b;
        ex_isa_pkg::F3_SLL:  return a << sh;
        ex_isa_pkg::F3_SLT:  return {31'b0, less_signed(a, b)};
        ex_isa_pkg::F3_SLTU: return {31'b0, a < b};
        ex_isa_pkg::F3_XOR:  return a ^ b;
        ex_isa_pkg::F3_SR:   return alt ? ((a >> sh) | ({32{a[31]}} & ~(32'hffffffff >> sh)))
                                        : a >> sh;    // Sign fill for SRA
        ex_isa_pkg::F3_OR:   return a | b;
        default:             return a & b;
    endcase
endfunction

task automatic predict(logic v, ex_isa_pkg::word_t pc_v, ex_isa_pkg::word_t instr_v,
                       ex_isa_pkg::word_t a, ex_isa_pkg::word_t b);
    ex_isa_pkg::funct3_t f3;
    ex_isa_pkg::funct7_t f7;
    ex_isa_pkg::word_t   imm_i;
    logic                legal;
    f3             = instr_v[14:12];
    f7             = instr_v[31:25];
    imm_i          = {{20{instr_v[31]}}, instr_v[31:20]};
    legal          = 1'b1;
    exp_valid      = v;
    exp_rd         = instr_v[11:7];
    exp_result     = pc_v + 32'd4;    // Link value unless overridden
    exp_has_result = 1'b1;
    exp_redirect   = 1'b0;
    exp_target     = '0;
    case (instr_v[6:0])
        ex_isa_pkg::OPC_OP: begin
            legal      = f7 == ex_isa_pkg::FUNCT7_BASE || (f7 == ex_isa_pkg::FUNCT7_ALT &&
                         (f3 == ex_isa_pkg::F3_ADD || f3 == ex_isa_pkg::F3_SR));
            exp_result = alu_ref(f3, f7 == ex_isa_pkg::FUNCT7_ALT, a, b);
        end
        ex_isa_pkg::OPC_OP_IMM: begin
            if (f3 == ex_isa_pkg::F3_SLL) begin
                legal = f7 == ex_isa_pkg::FUNCT7_BASE;
            end else if (f3 == ex_isa_pkg::F3_SR) begin
                legal = f7 == ex_isa_pkg::FUNCT7_BASE || f7 == ex_isa_pkg::FUNCT7_ALT;
            end
            exp_result = alu_ref(f3, f3 == ex_isa_pkg::F3_SR && f7 == ex_isa_pkg::FUNCT7_ALT,
                                 a, imm_i);    // No SUBI
        end
        ex_isa_pkg::OPC_LUI:   exp_result = {instr_v[31:12], 12'h000};
        ex_isa_pkg::OPC_AUIPC: exp_result = pc_v + {instr_v[31:12], 12'h000};
        ex_isa_pkg::OPC_BRANCH: begin
            exp_has_result = 1'b0;
            exp_target     = pc_v + {{20{instr_v[31]}}, instr_v[7], instr_v[30:25],
                                     instr_v[11:8], 1'b0};
            case (f3)
                ex_isa_pkg::F3_BEQ:  exp_redirect = a == b;
                ex_isa_pkg::F3_BNE:  exp_redirect = a != b;
                ex_isa_pkg::F3_BLT:  exp_redirect = less_signed(a, b);
                ex_isa_pkg::F3_BGE:  exp_redirect = !less_signed(a, b);
                ex_isa_pkg::F3_BLTU: exp_redirect = a < b;
                ex_isa_pkg::F3_BGEU: exp_redirect = a >= b;
                default:             legal        = 1'b0;
            endcase
        end
        ex_isa_pkg::OPC_JAL: begin
            exp_redirect = 1'b1;
            exp_target   = pc_v + {{12{instr_v[31]}}, instr_v[19:12], instr_v[20],
                                   instr_v[30:21], 1'b0};
        end
        ex_isa_pkg::OPC_JALR: begin
            legal        = f3 == ex_isa_pkg::F3_JALR;
            exp_redirect = 1'b1;
            exp_target   = (a + imm_i) & ~32'd1;    // Bit 0 cleared
        end
        default: legal = 1'b0;
    endcase
    exp_illegal    = v && !legal;
    exp_rd_write   = v && legal && instr_v[6:0] != ex_isa_pkg::OPC_BRANCH && exp_rd != '0;
    exp_redirect   = v && legal && exp_redirect;
    exp_has_result = v && legal && exp_has_result;
endtask

task automatic check_word(string name, ex_isa_pkg::word_t got, ex_isa_pkg::word_t exp);
    if (got !== exp) begin
        $display("FAIL %s got %h expected %h", name, got, exp);
        $display("** FAIL **");
        $fatal(1, "Mismatch on %s", name);
    end
endtask

task automatic check_idx(string name, ex_isa_pkg::reg_idx_t got, ex_isa_pkg::reg_idx_t exp);
    if (got !== exp) begin
        $display("FAIL %s got %h expected %h", name, got, exp);
        $display("** FAIL **");
        $fatal(1, "Mismatch on %s", name);
    end
endtask

task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
        $display("FAIL %s got %h expected %h", name, got, exp);
        $display("** FAIL **");
        $fatal(1, "Mismatch on %s", name);
    end
endtask

task automatic check_outputs();
    if (pending) begin
        check_flag("out_valid", out_valid, exp_valid);
        check_flag("rd_write", rd_write, exp_rd_write);
        check_flag("redirect", redirect, exp_redirect);
        check_flag("illegal", illegal, exp_illegal);
        if (exp_has_result) begin
            check_word("result", result, exp_result);
            check_idx("rd", rd, exp_rd);
        end
        if (exp_redirect) check_word("target", target, exp_target);
    end
endtask

// Checks the previous item and presents the next one
task automatic issue(logic v, ex_isa_pkg::word_t pc_v, ex_isa_pkg::word_t instr_v,
                     ex_isa_pkg::word_t a, ex_isa_pkg::word_t b);
    @(posedge clk);
    #DRIVE_DELAY;
    check_outputs();
    in_valid = v;
    pc       = pc_v;
    instr    = instr_v;
    rs1_data = a;
    rs2_data = b;
    predict(v, pc_v, instr_v, a, b);
    pending  = 1'b1;
endtask

task automatic idle_cycle();
    issue(1'b0, '0, '0, '0, '0);
endtask

task automatic test_r_type();
    ex_isa_pkg::word_t a;
    ex_isa_pkg::word_t b;
    for (int i = 0; i < 8; i++) begin
        a = next_rand();
        b = next_rand();
        issue(1'b1, 32'h100 + 4 * i, enc_r(ex_isa_pkg::FUNCT7_BASE, i[2:0],
              ex_isa_pkg::reg_idx_t'(i + 1)), a, b);
    end
    a = next_rand();
    b = next_rand();
    issue(1'b1, 32'h120, enc_r(ex_isa_pkg::FUNCT7_ALT, ex_isa_pkg::F3_ADD, 5'd9), a, b);
    a = next_rand();
    issue(1'b1, 32'h124, enc_r(ex_isa_pkg::FUNCT7_ALT, ex_isa_pkg::F3_SR, 5'd10), a, b);
    issue(1'b1, 32'h128, enc_r(ex_isa_pkg::FUNCT7_BASE, ex_isa_pkg::F3_SLT, 5'd11),
          32'h8000_0000, 32'h1);    // Most negative below one
    issue(1'b1, 32'h12c, enc_r(ex_isa_pkg::FUNCT7_BASE, ex_isa_pkg::F3_SLTU, 5'd12),
          32'h8000_0000, 32'h1);
    issue(1'b1, 32'h130, enc_r(ex_isa_pkg::FUNCT7_BASE, ex_isa_pkg::F3_SLT, 5'd13),
          32'h1, 32'hffff_ffff);
    issue(1'b1, 32'h134, enc_r(ex_isa_pkg::FUNCT7_BASE, ex_isa_pkg::F3_SLTU, 5'd14),
          32'h1, 32'hffff_ffff);
    issue(1'b1, 32'h138, enc_r(ex_isa_pkg::FUNCT7_ALT, ex_isa_pkg::F3_SR, 5'd15),
          32'h8000_0000, 32'h3f);    // Upper shift bits ignored
endtask

task automatic test_i_type();
    logic [5:0][2:0]    f3s;
    logic [5:0][11:0]   imms;
    ex_isa_pkg::shamt_t sh;
    f3s  = {ex_isa_pkg::F3_ADD, ex_isa_pkg::F3_SLT, ex_isa_pkg::F3_SLTU,
            ex_isa_pkg::F3_XOR, ex_isa_pkg::F3_OR, ex_isa_pkg::F3_AND};
    imms = {12'hffb, 12'hfff, 12'hfff, 12'h800, 12'hf0f, 12'h8ff};    // All negative
    for (int i = 0; i < 6; i++) begin
        issue(1'b1, 32'h200 + 4 * i, enc_i(imms[i], f3s[i], 5'd20, ex_isa_pkg::OPC_OP_IMM),
              next_rand(), '0);
    end
    sh = ex_isa_pkg::shamt_t'(next_rand());
    issue(1'b1, 32'h220, enc_i({7'b0, sh}, ex_isa_pkg::F3_SLL, 5'd21, ex_isa_pkg::OPC_OP_IMM),
          next_rand(), '0);
    sh = ex_isa_pkg::shamt_t'(next_rand());
    issue(1'b1, 32'h224, enc_i({7'b0, sh}, ex_isa_pkg::F3_SR, 5'd22, ex_isa_pkg::OPC_OP_IMM),
          next_rand(), '0);
    sh = ex_isa_pkg::shamt_t'(next_rand());
    issue(1'b1, 32'h228, enc_i({ex_isa_pkg::FUNCT7_ALT, sh}, ex_isa_pkg::F3_SR, 5'd23,
          ex_isa_pkg::OPC_OP_IMM), 32'h8000_0000 | next_rand(), '0);    // SRAI on a negative
    issue(1'b1, 32'h22c, enc_i(12'h7ff, ex_isa_pkg::F3_ADD, 5'd0, ex_isa_pkg::OPC_OP_IMM),
          next_rand(), '0);    // Write to x0
endtask

task automatic test_upper();
    issue(1'b1, 32'h300, {20'hdead5, 5'd3, ex_isa_pkg::OPC_LUI}, next_rand(), '0);
    issue(1'b1, 32'h304, {20'h80000, 5'd4, ex_isa_pkg::OPC_LUI}, next_rand(), '0);
    issue(1'b1, 32'h0001_2308, {20'h12345, 5'd5, ex_isa_pkg::OPC_AUIPC}, '0, '0);
    issue(1'b1, 32'h0001_230c, {20'hfffff, 5'd6, ex_isa_pkg::OPC_AUIPC}, '0, '0);
endtask

task automatic test_branches();
    logic [5:0][2:0]   f3s;
    ex_isa_pkg::word_t x;
    ex_isa_pkg::word_t y;
    ex_isa_pkg::word_t pc_v;
    f3s = {ex_isa_pkg::F3_BEQ, ex_isa_pkg::F3_BNE, ex_isa_pkg::F3_BLT,
           ex_isa_pkg::F3_BGE, ex_isa_pkg::F3_BLTU, ex_isa_pkg::F3_BGEU};
    x   = 32'hffff_fff0;    // Negative signed and large unsigned
    y   = 32'h0000_0001;
    for (int i = 0; i < 6; i++) begin
        pc_v = 32'h8000 + 32'h10 * i;
        issue(1'b1, pc_v, enc_b(13'h0040, f3s[i]), x, y);        // Forward
        issue(1'b1, pc_v + 4, enc_b(13'h1fc0, f3s[i]), y, x);    // Back by 64
        issue(1'b1, pc_v + 8, enc_b(13'h0ffe, f3s[i]), x, x);    // Far forward and equal
    end
    issue(1'b1, 32'h8100, enc_b(13'h0040, 3'b010), x, y);    // Reserved funct3
endtask

task automatic test_jumps();
    issue(1'b1, 32'h4000, enc_j(21'h000800, 5'd1), '0, '0);
    issue(1'b1, 32'h4004, enc_j(21'h1ff000, 5'd5), '0, '0);    // Back by 4096
    issue(1'b1, 32'h4008, enc_j(21'h000010, 5'd0), '0, '0);    // Link to x0
    issue(1'b1, 32'h400c, enc_i(12'h004, ex_isa_pkg::F3_JALR, 5'd1, ex_isa_pkg::OPC_JALR),
          32'h0000_1001, '0);    // Odd sum
    issue(1'b1, 32'h4010, enc_i(12'hff1, ex_isa_pkg::F3_JALR, 5'd7, ex_isa_pkg::OPC_JALR),
          32'h0000_2000, '0);
endtask

task automatic test_stream_reset();
    issue(1'b1, 32'h500, enc_r(ex_isa_pkg::FUNCT7_BASE, ex_isa_pkg::F3_ADD, 5'd8),
          next_rand(), 32'h55);
    issue(1'b1, 32'h504, enc_j(21'h000100, 5'd1), '0, '0);
    issue(1'b1, 32'h508, enc_b(13'h0020, ex_isa_pkg::F3_BNE), 32'h1, 32'h2);
    idle_cycle();    // Bubble
    issue(1'b1, 32'h50c, enc_i(12'h000, 3'b010, 5'd3, 7'b0000011), 32'h1000, '0);    // LW
    issue(1'b1, 32'h510, enc_r(7'b0000001, ex_isa_pkg::F3_ADD, 5'd4), 32'h3, 32'h7);  // MUL
    issue(1'b1, 32'h514, enc_j(21'h000200, 5'd1), '0, '0);
    reset = 1'b1;    // Lands on the edge that captures the JAL
    predict(1'b0, '0, '0, '0, '0);
    idle_cycle();
    reset = 1'b0;
    idle_cycle();
endtask

// File: verif/tb_ex_top.sv
module tb_ex_top;

    localparam int DRIVE_DELAY  = 10;    // Input skew after the rising edge
    localparam int RESET_CYCLES = 10;
    // Reset plus one edge per drive in each test and the final flush
    localparam int TEST_CYCLES  = RESET_CYCLES + 15 + 10 + 4 + 19 + 5 + 9 + 1;
    localparam int CYCLE_LIMIT  = 2 * TEST_CYCLES;

    logic                 clk;
    logic                 reset;
    logic                 in_valid;
    ex_isa_pkg::word_t    pc, instr, rs1_data, rs2_data;
    logic                 out_valid;
    ex_isa_pkg::word_t    result;
    ex_isa_pkg::reg_idx_t rd;
    logic                 rd_write, redirect, illegal;
    ex_isa_pkg::word_t    target;

    // Expected response to the item driven one edge earlier
    logic                 pending;           // Something to check at the next edge
    logic                 exp_valid;
    logic                 exp_rd_write;
    logic                 exp_redirect;
    logic                 exp_illegal;
    logic                 exp_has_result;    // Result and rd are meaningful
    ex_isa_pkg::word_t    exp_result;
    ex_isa_pkg::word_t    exp_target;
    ex_isa_pkg::reg_idx_t exp_rd;

    ex_isa_pkg::word_t    lcg_state;         // Random generator state
    int                   cycles = 0;        // Watchdog count

    // Classic 32-bit LCG step
    function automatic ex_isa_pkg::word_t next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    `include "tb_ex_tasks.svh"

    ex_top i_dut (.clk, .reset, .in_valid, .pc, .instr, .rs1_data, .rs2_data, .out_valid,
        .result, .rd, .rd_write, .redirect, .illegal, .target);

    initial begin
        clk = 1'b0;
        forever #50 clk = !clk;    // Period 100
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the test sequence never finished", cycles);
            $display("** FAIL **");
            $fatal(1, "Simulation stopped by the watchdog");
        end
    end

    initial begin
        reset     = 1'b1;
        in_valid  = 1'b0;
        pc        = '0;
        instr     = '0;
        rs1_data  = '0;
        rs2_data  = '0;
        pending   = 1'b0;
        lcg_state = 32'h115c757a;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        predict(1'b0, '0, '0, '0, '0);    // Flags low straight after reset
        pending = 1'b1;
        test_r_type();
        test_i_type();
        test_upper();
        test_branches();
        test_jumps();
        test_stream_reset();
        idle_cycle();                     // Drains the last item
        $display("** PASS **");
        $finish;
    end

endmodule

// File: tb.f
+incdir+verif
source/ex_isa_pkg.sv
source/ex_ctrl_pkg.sv
source/ex_imm_gen.sv
source/ex_decode.sv
source/ex_alu.sv
source/ex_branch_unit.sv
source/ex_output_stage.sv
source/ex_top.sv
verif/tb_ex_top.sv

// File: Bender.yml
package:
  name: ex_stage

sources:
  - files:
      - source/ex_isa_pkg.sv
      - source/ex_ctrl_pkg.sv
      - source/ex_imm_gen.sv
      - source/ex_decode.sv
      - source/ex_alu.sv
      - source/ex_branch_unit.sv
      - source/ex_output_stage.sv
      - source/ex_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_ex_top.sv
